// ==== src/memtest_pkg.sv ====
package memtest_pkg;

   localparam int APP_ADDR_W = 30;        // Native-port address width of the controller.
   localparam int DATA_W = 32;

   typedef logic [APP_ADDR_W-1:0] app_addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [15:0]           iter_t;
   typedef logic [7:0]            err_cnt_t;

   typedef enum logic [2:0] {
      CMD_WRITE = 3'd0,
      CMD_READ  = 3'd1
   } app_cmd_e;

   typedef enum logic [3:0] {
      S_IDLE,
      S_WRITE_WAIT,
      S_WRITE_CMD,
      S_WRITE_END,
      S_READ_START,
      S_READ_CMD,
      S_READ_NEXT,
      S_WAIT_READS,
      S_RESEED
   } seq_state_e;

   typedef struct packed {
      logic       psel;
      logic       penable;
      logic       pwrite;
      logic [7:0] paddr;
      data_t      pwdata;
   } apb_req_t;

   typedef struct packed {
      data_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   // Signals driven towards the DDR3 controller.
   typedef struct packed {
      app_addr_t addr;
      app_cmd_e  cmd;
      logic      en;
      data_t     wdf_data;
      logic      wdf_wren;
      logic      wdf_end;
   } app_req_t;

   typedef struct packed {
      data_t rd_data;
      logic  rd_data_end;
      logic  rd_data_valid;
      logic  rdy;
      logic  wdf_rdy;
   } app_rsp_t;

   localparam logic [7:0] REG_CTRL     = 8'h00;
   localparam logic [7:0] REG_INCR     = 8'h04;
   localparam logic [7:0] REG_STOP     = 8'h08;
   localparam logic [7:0] REG_STATUS   = 8'h0C;
   localparam logic [7:0] REG_ERR_ADDR = 8'h10;

endpackage

// ==== src/memtest_apb_regs.sv ====
`timescale 1ns/1ps

module memtest_apb_regs import memtest_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  apb_req_t  apb_req,
   input  logic      pass,
   input  logic      fail,
   input  err_cnt_t  errors,
   input  iter_t     iteration,
   input  app_addr_t err_addr,
   output apb_rsp_t  apb_rsp,
   output logic      run,
   output logic      clear_fail,
   output logic      start,
   output app_addr_t incr,
   output app_addr_t stop
);

   logic  access;
   logic  wr_en;
   logic  addr_ok;
   logic  run_d;
   data_t rdata;

   assign access = apb_req.psel && apb_req.penable;   // Second cycle of a transfer.
   assign wr_en  = access && apb_req.pwrite;

   // Write side. Everything lands at the end of the access cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         run        <= 1'b0;
         clear_fail <= 1'b0;
         incr       <= '0;
         stop       <= '0;
      end else begin
         clear_fail <= 1'b0;                           // Pulse lasts a single cycle.
         if (wr_en) begin
            case (apb_req.paddr)
               REG_CTRL: begin
                  run        <= apb_req.pwdata[0];
                  clear_fail <= apb_req.pwdata[1];
               end
               REG_INCR: incr <= apb_req.pwdata[APP_ADDR_W-1:0];
               REG_STOP: stop <= apb_req.pwdata[APP_ADDR_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // A rising run bit starts a fresh test on the following clock.
   always_ff @(posedge clk) begin
      if (reset) begin
         run_d <= 1'b0;
      end else begin
         run_d <= run;
      end
   end

   assign start = run && !run_d;

   // Read multiplexer, valid during the access cycle.
   always_comb begin
      addr_ok = 1'b1;
      rdata   = '0;
      case (apb_req.paddr)
         REG_CTRL:     rdata = {30'd0, clear_fail, run};
         REG_INCR:     rdata = {{(DATA_W-APP_ADDR_W){1'b0}}, incr};
         REG_STOP:     rdata = {{(DATA_W-APP_ADDR_W){1'b0}}, stop};
         REG_STATUS:   rdata = {iteration, errors, 6'd0, fail, pass};
         REG_ERR_ADDR: rdata = {{(DATA_W-APP_ADDR_W){1'b0}}, err_addr};
         default:      addr_ok = 1'b0;
      endcase
   end

   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pready  = 1'b1;                      // No wait states.
   assign apb_rsp.pslverr = access && !addr_ok;

endmodule

// ==== src/memtest_pattern_gen.sv ====
`timescale 1ns/1ps

module memtest_pattern_gen import memtest_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      load_seed,
   input  iter_t     iteration,
   input  logic      step,
   input  app_addr_t wr_addr,
   input  app_addr_t vfy_addr,
   output data_t     wr_data,
   output data_t     exp_data,
   output logic      nonzero
);

   data_t lfsr;

   // Taps at bits 31, 21, 1 and 0.
   always_ff @(posedge clk) begin
      if (reset) begin
         lfsr <= '0;
      end else if (load_seed) begin
         lfsr <= {iteration, ~iteration};              // Seed differs every iteration.
      end else if (step) begin
         lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      end
   end

   // The address is folded in so that aliased addresses show up as errors.
   assign wr_data  = lfsr ^ {{(DATA_W-APP_ADDR_W){1'b0}}, wr_addr};
   assign exp_data = lfsr ^ {{(DATA_W-APP_ADDR_W){1'b0}}, vfy_addr};

   assign nonzero = |lfsr;   // An all-zero register would never move.

endmodule

// ==== src/memtest_sequencer.sv ====
`timescale 1ns/1ps

module memtest_sequencer import memtest_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      run,
   input  logic      calib_done,
   input  app_addr_t incr,
   input  app_addr_t stop,
   input  app_rsp_t  app_rsp,
   output app_req_t  app_req,
   output logic      load_seed,
   output logic      step,
   output app_addr_t vfy_addr,
   output iter_t     iteration,
   output logic      iteration_done,
   output logic      rd_beat
);

   seq_state_e state;
   seq_state_e next_state;
   app_addr_t  addr;
   logic       reset_addr;
   logic       incr_addr;
   logic       wr_beat;
   logic       writing;
   logic       reading;
   logic       reads_done;

   assign writing = state inside {S_WRITE_WAIT, S_WRITE_CMD, S_WRITE_END};
   assign reading = state inside {S_READ_START, S_READ_CMD, S_READ_NEXT, S_WAIT_READS};
   assign rd_beat = reading && app_rsp.rd_data_valid;
   assign step    = wr_beat || rd_beat;                // One LFSR shift per beat.

   always_comb begin
      next_state       = state;
      app_req.addr     = addr;
      app_req.cmd      = writing ? CMD_WRITE : CMD_READ;
      app_req.en       = 1'b0;
      app_req.wdf_data = '0;                           // Payload comes from the pattern generator.
      app_req.wdf_wren = 1'b0;
      app_req.wdf_end  = 1'b0;
      load_seed        = 1'b0;
      reset_addr       = 1'b0;
      incr_addr        = 1'b0;
      wr_beat          = 1'b0;
      iteration_done   = 1'b0;
      case (state)
         S_IDLE: begin
            if (run && calib_done && app_rsp.rdy && app_rsp.wdf_rdy) begin
               reset_addr = 1'b1;
               load_seed  = 1'b1;
               next_state = S_WRITE_CMD;
            end
         end
         S_WRITE_WAIT: begin
            if (app_rsp.rdy && app_rsp.wdf_rdy) next_state = S_WRITE_CMD;
         end
         S_WRITE_CMD: begin
            // Command and first beat go out together.
            app_req.en       = 1'b1;
            app_req.wdf_wren = 1'b1;
            if (app_rsp.rdy && app_rsp.wdf_rdy) begin
               wr_beat    = 1'b1;
               next_state = S_WRITE_END;
            end
         end
         S_WRITE_END: begin
            app_req.wdf_wren = 1'b1;
            app_req.wdf_end  = 1'b1;
            if (app_rsp.wdf_rdy) begin
               wr_beat = 1'b1;
               if (!run) begin
                  next_state = S_IDLE;                 // Burst is complete, safe to stop.
               end else if (addr == stop) begin
                  reset_addr = 1'b1;
                  next_state = S_READ_START;
               end else begin
                  incr_addr  = 1'b1;
                  next_state = app_rsp.rdy ? S_WRITE_CMD : S_WRITE_WAIT;
               end
            end
         end
         S_READ_START: begin
            if (app_rsp.rdy) begin
               load_seed  = 1'b1;                      // Replay the write sequence.
               next_state = S_READ_CMD;
            end
         end
         S_READ_CMD: begin
            app_req.en = 1'b1;
            if (app_rsp.rdy) next_state = S_READ_NEXT;
         end
         S_READ_NEXT: begin
            if (!run) begin
               next_state = S_IDLE;
            end else if (app_rsp.rdy) begin
               if (addr == stop) begin
                  next_state = S_WAIT_READS;
               end else begin
                  incr_addr  = 1'b1;
                  next_state = S_READ_CMD;
               end
            end
         end
         S_WAIT_READS: begin
            if (!run) begin
               next_state = S_IDLE;
            end else if (reads_done) begin
               reset_addr     = 1'b1;
               iteration_done = 1'b1;
               next_state     = S_RESEED;
            end
         end
         S_RESEED: begin
            load_seed  = 1'b1;                         // Picks up the new iteration count.
            next_state = S_WRITE_WAIT;
         end
         default: next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= S_IDLE;
         addr       <= '0;
         vfy_addr   <= '0;
         reads_done <= 1'b0;
         iteration  <= '0;
      end else begin
         state <= next_state;
         if (reset_addr) begin
            addr       <= '0;
            vfy_addr   <= '0;
            reads_done <= 1'b0;
         end else begin
            if (incr_addr) addr <= addr + incr;
            // The verify address parks at stop once the last burst is back.
            if (rd_beat && app_rsp.rd_data_end) begin
               if (vfy_addr == stop) reads_done <= 1'b1;
               else vfy_addr <= vfy_addr + incr;
            end
         end
         if (state == S_IDLE) iteration <= '0;
         else if (iteration_done) iteration <= iteration + 1'b1;
      end
   end

endmodule

// ==== src/memtest_result_log.sv ====
`timescale 1ns/1ps

module memtest_result_log import memtest_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   input  logic      clear_fail,
   input  logic      rd_beat,
   input  data_t     rd_data,
   input  data_t     exp_data,
   input  app_addr_t vfy_addr,
   input  logic      iteration_done,
   input  logic      nonzero,
   input  logic      run,
   output logic      pass,
   output logic      fail,
   output err_cnt_t  errors,
   output app_addr_t err_addr
);

   logic mismatch;

   assign mismatch = rd_beat && (rd_data != exp_data);

   always_ff @(posedge clk) begin
      if (reset) begin
         pass <= 1'b0;
      end else if (!run || clear_fail || mismatch) begin
         pass <= 1'b0;
      end else if (iteration_done && !fail && nonzero) begin
         pass <= 1'b1;   // A clean pass over the whole range.
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fail     <= 1'b0;
         errors   <= '0;
         err_addr <= '0;
      end else if (start || clear_fail) begin
         fail     <= 1'b0;
         errors   <= '0;
         err_addr <= '0;
      end else if (mismatch) begin
         fail <= 1'b1;                                 // Sticky until cleared.
         if (errors == '0) err_addr <= vfy_addr;       // Only the first failure is kept.
         if (errors != '1) errors <= errors + 1'b1;
      end
   end

endmodule

// ==== src/memtest_top.sv ====
`timescale 1ns/1ps

module memtest_top import memtest_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  apb_req_t apb_req,
   input  logic     calib_done,
   input  app_rsp_t app_rsp,
   output apb_rsp_t apb_rsp,
   output app_req_t app_req
);

   logic      run;
   logic      clear_fail;
   logic      start;
   app_addr_t incr;
   app_addr_t stop;
   logic      pass;
   logic      fail;
   err_cnt_t  errors;
   app_addr_t err_addr;
   iter_t     iteration;
   app_req_t  seq_req;
   logic      load_seed;
   logic      step;
   app_addr_t vfy_addr;
   logic      iteration_done;
   logic      rd_beat;
   data_t     wr_data;
   data_t     exp_data;
   logic      nonzero;

   // Write payload joins the sequencer's command fields here.
   always_comb begin
      app_req          = seq_req;
      app_req.wdf_data = wr_data;
   end

   memtest_apb_regs u_regs (
      .clk(clk), .reset(reset), .apb_req(apb_req),
      .pass(pass), .fail(fail), .errors(errors), .iteration(iteration),
      .err_addr(err_addr), .apb_rsp(apb_rsp), .run(run), .clear_fail(clear_fail),
      .start(start), .incr(incr), .stop(stop)
   );

   memtest_sequencer u_seq (
      .clk(clk), .reset(reset), .run(run), .calib_done(calib_done),
      .incr(incr), .stop(stop), .app_rsp(app_rsp), .app_req(seq_req),
      .load_seed(load_seed), .step(step), .vfy_addr(vfy_addr),
      .iteration(iteration), .iteration_done(iteration_done), .rd_beat(rd_beat)
   );

   memtest_pattern_gen u_pattern (
      .clk(clk), .reset(reset), .load_seed(load_seed), .iteration(iteration),
      .step(step), .wr_addr(seq_req.addr), .vfy_addr(vfy_addr),
      .wr_data(wr_data), .exp_data(exp_data), .nonzero(nonzero)
   );

   memtest_result_log u_log (
      .clk(clk), .reset(reset), .start(start), .clear_fail(clear_fail),
      .rd_beat(rd_beat), .rd_data(app_rsp.rd_data), .exp_data(exp_data),
      .vfy_addr(vfy_addr), .iteration_done(iteration_done), .nonzero(nonzero),
      .run(run), .pass(pass), .fail(fail), .errors(errors), .err_addr(err_addr)
   );

endmodule

// ==== tests/memtest_chk.sv ====
`timescale 1ns/1ps

module memtest_chk import memtest_pkg::*; (
   input logic       clk,
   input logic       reset,
   input app_req_t   app_req,
   input app_rsp_t   app_rsp,
   input app_addr_t  stop,
   input seq_state_e state
);

   int fail_count = 0;

   end_has_wren: assert property (@(posedge clk) disable iff (reset)
      app_req.wdf_end |-> app_req.wdf_wren)
      else begin
         fail_count++;
         $error("wdf_end high without wdf_wren");
      end

   // A command waiting for rdy must not change under the controller.
   cmd_stable: assert property (@(posedge clk) disable iff (reset)
      app_req.en && !app_rsp.rdy |=>
         app_req.en && $stable(app_req.addr) && $stable(app_req.cmd))
      else begin
         fail_count++;
         $error("command changed while waiting for rdy");
      end

   addr_in_range: assert property (@(posedge clk) disable iff (reset)
      app_req.en |-> app_req.addr <= stop)
      else begin
         fail_count++;
         $error("command address %0h above stop %0h", app_req.addr, stop);
      end

   idle_quiet: assert property (@(posedge clk) disable iff (reset)
      state == S_IDLE |-> !app_req.en && !app_req.wdf_wren)
      else begin
         fail_count++;
         $error("en or wdf_wren high in idle");
      end

endmodule

bind memtest_sequencer memtest_chk u_chk (
   .clk(clk), .reset(reset), .app_req(app_req), .app_rsp(app_rsp),
   .stop(stop), .state(state)
);

// ==== tests/memtest_scoreboard.sv ====
`timescale 1ns/1ps

module memtest_scoreboard import memtest_pkg::*; (
   input logic     clk,
   input logic     reset,
   input apb_req_t apb_req,
   input apb_rsp_t apb_rsp,
   input app_req_t app_req,
   input app_rsp_t app_rsp,
   input logic     quiet
);

   int        error_count = 0;
   int        tests_failed = 0;
   int        start_errors;
   int        iter;
   logic      in_read;
   data_t     lfsr;
   app_addr_t incr_q;
   app_addr_t stop_q;
   logic      covered [0:255];   // Write commands seen per address.

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      error_count++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic begin_test(input app_addr_t incr, input app_addr_t stop);
      int a;
      incr_q = incr;
      stop_q = stop;
      iter = 0;
      in_read = 1'b0;
      lfsr = {16'h0000, 16'hffff};   // Seed of iteration zero.
      for (a = 0; a < 256; a++) covered[a] = 1'b0;
      start_errors = error_count;
   endtask

   // Every APB access completes at once and only the listed offsets decode.
   always @(posedge clk) begin
      if (!reset && apb_req.psel && apb_req.penable) begin
         compare("pready", apb_rsp.pready, 1);
         compare("pslverr", apb_rsp.pslverr,
                 !(apb_req.paddr inside {REG_CTRL, REG_INCR, REG_STOP, REG_STATUS,
                                         REG_ERR_ADDR}));
      end
   end

   // Write beats are predicted from the seed rule and one shift per accepted beat.
   always @(posedge clk) begin
      if (!reset) begin
         if (app_req.wdf_wren && app_rsp.wdf_rdy) begin
            if (in_read) begin
               iter++;                   // First write beat after a read pass.
               in_read = 1'b0;
               lfsr = {iter[15:0], ~iter[15:0]};
            end
            compare("wr_data", app_req.wdf_data, lfsr ^ {2'b00, app_req.addr});
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         end
         if (app_req.en && app_rsp.rdy) begin
            if (app_req.cmd == CMD_READ) in_read = 1'b1;
            else if (app_req.addr > stop_q) report_failure("write command above the stop address");
            else covered[app_req.addr[7:0]] = 1'b1;
         end
         if (quiet && app_req.en) report_failure("command issued after the engine went idle");
      end
   end

   task automatic finish_test(input int t, input logic [31:0] g_pass, input logic [31:0] g_fail,
                              input logic [31:0] g_addr, input data_t status,
                              input data_t err_addr, input data_t clr_status,
                              input data_t clr_addr);
      int a;
      compare("status.pass", status[0], g_pass);
      compare("status.fail", status[1], g_fail);
      compare("err_addr", err_addr, g_addr);
      if (g_fail == 0) begin
         compare("status.errors", status[15:8], 0);
      end else if (status[15:8] == 0 || status[15:8] > status[31:16] + 1) begin
         report_failure($sformatf("error count %0d does not fit %0d iterations",
                                  status[15:8], status[31:16]));
      end
      for (a = 0; incr_q != 0 && a <= stop_q; a += incr_q) begin
         if (!covered[a]) report_failure($sformatf("address %0h was never written", a));
      end
      compare("status after clear", clr_status, 0);
      compare("err_addr after clear", clr_addr, 0);
      if (error_count == start_errors) begin
         $display("test %0d: %0d iterations, ok", t, status[31:16]);
      end else begin
         tests_failed++;
         $display("test %0d: %0d iterations, %0d errors", t, status[31:16],
                  error_count - start_errors);
      end
   endtask

   task automatic print_summary(input int n_tests, input int assert_fails);
      $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
               n_tests, tests_failed, error_count, assert_fails);
   endtask

endmodule

// ==== tests/memtest_tb.sv ====
`timescale 1ns/1ps

module memtest_tb import memtest_pkg::*; ();

   localparam int MAX_TESTS = 16;
   localparam int COLS      = 7;

   logic        clk = 1'b0;
   logic        reset;
   logic        calib_done;
   logic        quiet;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   app_req_t    app_req;
   app_rsp_t    app_rsp;
   logic [31:0] golden [0:MAX_TESTS*COLS-1];
   data_t       mem0 [0:255];             // First beat of each burst.
   data_t       mem1 [0:255];
   app_addr_t   rd_queue [$];
   longint      due_queue [$];
   longint      cycle;
   longint      due;
   longint      last_due;
   longint      watchdog_cycles;
   logic [31:0] fault_addr;
   logic        second_beat;
   logic        stall;
   data_t       beat;
   integer      seed = 32'h0e6b1e8e;
   int          n_tests;
   int          t;

   always #2 clk = ~clk;

   memtest_top UUT (
      .clk(clk), .reset(reset), .apb_req(apb_req), .calib_done(calib_done),
      .app_rsp(app_rsp), .apb_rsp(apb_rsp), .app_req(app_req)
   );

   memtest_scoreboard sb (
      .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .app_req(app_req), .app_rsp(app_rsp), .quiet(quiet)
   );

   // Behavioural memory on the native port with random stalls and read latency.
   always @(posedge clk) begin
      if (reset) begin
         app_rsp <= '0;
         rd_queue.delete();
         due_queue.delete();
         second_beat = 1'b0;
         cycle = 0;
         last_due = 0;
      end else begin
         cycle++;
         stall = ($unsigned($random(seed)) % 5) == 0;   // Both ready lines drop together.
         app_rsp.rdy     <= !stall;
         app_rsp.wdf_rdy <= !stall;
         if (app_req.wdf_wren && app_rsp.wdf_rdy) begin
            if (app_req.wdf_end) mem1[app_req.addr[7:0]] = app_req.wdf_data;
            else mem0[app_req.addr[7:0]] = app_req.wdf_data;
         end
         if (app_req.en && app_rsp.rdy && app_req.cmd == CMD_READ) begin
            due = cycle + 2 + ($unsigned($random(seed)) % 5);
            if (due < last_due + 2) due = last_due + 2;  // Bursts come back in order.
            last_due = due;
            rd_queue.push_back(app_req.addr);
            due_queue.push_back(due);
         end
         app_rsp.rd_data_valid <= 1'b0;
         app_rsp.rd_data_end   <= 1'b0;
         if (rd_queue.size() != 0 && cycle >= due_queue[0]) begin
            app_rsp.rd_data_valid <= 1'b1;
            if (!second_beat) begin
               beat = mem0[rd_queue[0][7:0]];
               if ({2'b00, rd_queue[0]} == fault_addr) beat[0] = ~beat[0];
               app_rsp.rd_data <= beat;
               second_beat = 1'b1;
            end else begin
               app_rsp.rd_data     <= mem1[rd_queue[0][7:0]];
               app_rsp.rd_data_end <= 1'b1;
               second_beat = 1'b0;
               void'(rd_queue.pop_front());
               void'(due_queue.pop_front());
            end
         end
      end
   end

   task automatic apb_xfer(input logic write, input logic [7:0] addr, input data_t wdata,
                           output data_t rdata);
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= write;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;             // Middle of the access cycle.
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input data_t data);
      data_t ignored;
      apb_xfer(1'b1, addr, data, ignored);
   endtask

   task automatic run_test(input int idx);
      logic [31:0] g [0:COLS-1];
      data_t       status;
      data_t       err_addr;
      data_t       clr_status;
      data_t       clr_addr;
      int          c;
      int          polls;
      for (c = 0; c < COLS; c++) g[c] = golden[idx*COLS+c];
      for (c = 0; c < 256; c++) begin
         mem0[c] = '0;
         mem1[c] = '0;
      end
      fault_addr = g[2];
      quiet <= 1'b0;
      sb.begin_test(g[0][APP_ADDR_W-1:0], g[1][APP_ADDR_W-1:0]);
      reg_write(8'h14, 32'h3);            // An unlisted offset answers with an error.
      reg_write(REG_INCR, g[0]);
      reg_write(REG_STOP, g[1]);
      reg_write(REG_CTRL, 32'h1);
      status = '0;
      while (status[31:16] < g[3][15:0]) apb_xfer(1'b0, REG_STATUS, '0, status);
      apb_xfer(1'b0, REG_STATUS, '0, status);
      apb_xfer(1'b0, REG_ERR_ADDR, '0, err_addr);
      reg_write(REG_CTRL, 32'h0);
      clr_status = status;
      polls = 0;
      // The iteration field only returns to zero once the engine is idle.
      while (clr_status[31:16] != 0 && polls < 50) begin
         apb_xfer(1'b0, REG_STATUS, '0, clr_status);
         polls++;
      end
      if (clr_status[31:16] != 0) sb.report_failure("engine did not return to idle");
      quiet <= 1'b1;
      while (rd_queue.size() != 0) @(posedge clk);
      repeat (8) @(posedge clk);
      reg_write(REG_CTRL, 32'h2);         // clear_fail with run left low.
      apb_xfer(1'b0, REG_STATUS, '0, clr_status);
      apb_xfer(1'b0, REG_ERR_ADDR, '0, clr_addr);
      sb.finish_test(idx, g[4], g[5], g[6], status, err_addr, clr_status, clr_addr);
   endtask

   initial begin
      reset = 1'b1;
      calib_done = 1'b0;
      quiet = 1'b0;
      apb_req = '0;
      app_rsp = '0;
      fault_addr = '1;
      $readmemh("tests/memtest_golden.txt", golden);
      n_tests = 0;
      watchdog_cycles = 1000;
      while (n_tests < MAX_TESTS && !$isunknown(golden[n_tests*COLS])) begin
         // Forty cycles per address covers stalls, read latency and polling.
         watchdog_cycles += (golden[n_tests*COLS+3] + 2) * 40 *
                            (golden[n_tests*COLS+1] / golden[n_tests*COLS] + 1) + 2000;
         n_tests++;
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      calib_done <= 1'b1;
      if (n_tests == 0) sb.report_failure("golden file holds no tests");
      for (t = 0; t < n_tests; t++) run_test(t);
      sb.print_summary(n_tests, UUT.u_seq.u_chk.fail_count);
      if (sb.error_count == 0 && UUT.u_seq.u_chk.fail_count == 0) $display("TEST PASSED");
      else $display("TEST FAILED");
      $finish;
   end

   initial begin
      #1;
      #(watchdog_cycles * 4);
      $display("Watchdog expired after %0d cycles before all tests finished", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== memtest.f ====
src/memtest_pkg.sv
src/memtest_apb_regs.sv
src/memtest_pattern_gen.sv
src/memtest_sequencer.sv
src/memtest_result_log.sv
src/memtest_top.sv
tests/memtest_chk.sv
tests/memtest_scoreboard.sv
tests/memtest_tb.sv

// ==== tests/memtest_golden.txt ====
// Columns (hex): incr stop fault_addr iterations pass fail err_addr
// A fault address of FFFFFFFF means no fault is injected.
1 0F FFFFFFFF 2 1 0 0
4 40 10 2 0 1 10
8 F8 FFFFFFFF 1 1 0 0
3 2D 1E 3 0 1 1E
1 0 FFFFFFFF 4 1 0 0
2 20 7 2 1 0 0
5 32 32 1 0 1 32
